// ==== tb/ts_vectors.txt ====
// columns: drop_mask (hex, one bit per channel)  channel  start byte (hex)
// one packet per line, byte k is start + k except byte 0, the 0x47 sync byte
// in order, nothing dropped
0 0 00
0 1 10
0 2 a5
0 3 fe
0 0 47
0 1 80
0 2 3c
0 3 c1
// mixed drop masks
2 1 11
2 0 22
5 2 33
5 3 44
8 3 55
f 1 66
1 1 77
9 2 88
// random reader request
0 0 01
0 1 fd
4 2 12
0 3 9a
0 2 ee
1 0 5b
0 1 c3
6 1 07
0 0 64
0 3 d8
// reader stall
0 2 31
0 0 b2
0 1 4e
2 1 99
0 3 0f
0 0 f0

// ==== all.f ====
rtl/ts_pkg.sv
rtl/ts_pkt_filter.sv
rtl/ts_beat_packer.sv
rtl/beat_buffer.sv
rtl/ts_byte_unpacker.sv
rtl/ts_stream_top.sv
tb/ts_checker.sv
tb/tb_ts_stream.sv

// ==== run.sh ====
#!/bin/sh
# compile the TS stream testbench with Verilator, run it, then scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_ts_stream -Mdir obj_dir
./obj_dir/Vtb_ts_stream > sim.log 2>&1
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failure"

// ==== tb/tb_ts_stream.sv ====
// testbench for the TS stream top, reads packet vectors and drives words and reader requests
// ts_checker compares the byte stream, this module sequences the tests and reports
`timescale 1ns/1ps

module tb_ts_stream;

    localparam int CHAN_W        = 2;
    localparam int BUF_DEPTH     = 8;
    localparam int PKT_BYTES     = 188;
    localparam int MAX_VEC       = 64;
    localparam int GRP_DROP      = 8;      // first vector of each test group
    localparam int GRP_RAND      = 16;
    localparam int GRP_STALL     = 26;
    localparam int READY_TIMEOUT = 3000;
    localparam int DRAIN_TIMEOUT = 20000;
    localparam int STALL_HOLD    = 400;
    localparam int REQ_HIGH      = 0;
    localparam int REQ_RAND      = 1;
    localparam int REQ_LOW       = 2;

    logic                 clk;
    logic                 rst;
    logic [31:0]          ts_in_data;
    logic                 ts_in_valid;
    logic                 ts_in_sop;
    logic                 ts_in_eop;
    logic [CHAN_W-1:0]    ts_in_chan;
    logic [2**CHAN_W-1:0] drop_mask;
    logic                 ts_in_ready;
    logic [7:0]           ts_out_data;
    logic                 ts_out_valid;
    logic                 ts_out_sync;
    logic [CHAN_W-1:0]    ts_out_chan;
    logic                 ts_out_req;
    logic                 exp_push;
    logic [CHAN_W-1:0]    exp_chan;
    logic [7:0]           exp_start;
    int                   chk_errs;
    int                   chk_bytes;
    int                   chk_syncs;
    int                   chk_pending;

    logic [2**CHAN_W-1:0] vec_mask [MAX_VEC];
    logic [CHAN_W-1:0]    vec_chan [MAX_VEC];
    logic [7:0]           vec_start [MAX_VEC];
    int                   n_vec;
    int                   kept_total;
    int                   tb_errs;
    int                   failed_tests;
    int                   req_mode;
    logic                 timed_out;

    ts_stream_top #(
        .CHAN_W       (CHAN_W),
        .BUF_DEPTH    (BUF_DEPTH)
    ) UUT (
        .clk          (clk),
        .rst          (rst),
        .ts_in_data   (ts_in_data),
        .ts_in_valid  (ts_in_valid),
        .ts_in_sop    (ts_in_sop),
        .ts_in_eop    (ts_in_eop),
        .ts_in_chan   (ts_in_chan),
        .drop_mask    (drop_mask),
        .ts_in_ready  (ts_in_ready),
        .ts_out_data  (ts_out_data),
        .ts_out_valid (ts_out_valid),
        .ts_out_sync  (ts_out_sync),
        .ts_out_chan  (ts_out_chan),
        .ts_out_req   (ts_out_req)
    );

    ts_checker #(
        .CHAN_W       (CHAN_W)
    ) u_checker (
        .clk          (clk),
        .rst          (rst),
        .ts_out_data  (ts_out_data),
        .ts_out_valid (ts_out_valid),
        .ts_out_sync  (ts_out_sync),
        .ts_out_chan  (ts_out_chan),
        .ts_out_req   (ts_out_req),
        .exp_push     (exp_push),
        .exp_chan     (exp_chan),
        .exp_start    (exp_start),
        .err_cnt      (chk_errs),
        .byte_cnt     (chk_bytes),
        .sync_cnt     (chk_syncs),
        .pending      (chk_pending)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // byte 0 is the sync byte, the rest count up from start
    function automatic logic [7:0] pkt_byte(input logic [7:0] start, input int k);
        if (k == 0)
            return 8'h47;
        return 8'(start + k);
    endfunction

    function automatic int total_errs();
        return tb_errs + chk_errs;
    endfunction

    task automatic read_vectors();
        int          fd;
        int          rc;
        string       line;
        logic [31:0] m;
        logic [31:0] c;
        logic [31:0] s;
        fd = $fopen("tb/ts_vectors.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open the vector file tb/ts_vectors.txt");
            tb_errs++;
        end
        else
        begin
            while (!$feof(fd) && n_vec < MAX_VEC)
            begin
                rc = $fgets(line, fd);
                if (rc > 1 && line[0] != "/" && $sscanf(line, "%h %h %h", m, c, s) == 3)
                begin
                    vec_mask[n_vec]  = m[2**CHAN_W-1:0];
                    vec_chan[n_vec]  = c[CHAN_W-1:0];
                    vec_start[n_vec] = s[7:0];
                    if (!m[c[CHAN_W-1:0]])
                        kept_total++;
                    n_vec++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic send_word(input logic [31:0] data, input logic sop, input logic eop,
                             input int idx);
        int waited;
        waited = 0;
        @(negedge clk);
        ts_in_data  = data;
        ts_in_valid = 1'b1;
        ts_in_sop   = sop;
        ts_in_eop   = eop;
        ts_in_chan  = vec_chan[idx];
        drop_mask   = vec_mask[idx];
        while (!ts_in_ready && waited < READY_TIMEOUT)
        begin
            @(negedge clk);
            waited++;
        end
        if (!ts_in_ready)
        begin
            $display("Timeout at %0t ns: ts_in_ready stayed low for %0d cycles", $time, waited);
            timed_out = 1'b1;
            tb_errs++;
        end
    endtask

    task automatic send_packet(input int idx);
        logic [31:0] word;
        if (!vec_mask[idx][vec_chan[idx]])
        begin
            @(negedge clk);
            exp_push  = 1'b1;    // checker queues the packet
            exp_chan  = vec_chan[idx];
            exp_start = vec_start[idx];
            @(negedge clk);
            exp_push  = 1'b0;
        end
        for (int w = 0; w < PKT_BYTES / 4 && !timed_out; w++)
        begin
            for (int b = 0; b < 4; b++)
                word = {word[23:0], pkt_byte(vec_start[idx], 4 * w + b)};
            send_word(word, w == 0, w == PKT_BYTES / 4 - 1, idx);
        end
        @(negedge clk);
        ts_in_valid = 1'b0;
        ts_in_sop   = 1'b0;
        ts_in_eop   = 1'b0;
    endtask

    task automatic send_range(input int first, input int last);
        for (int i = first; i < last && i < n_vec && !timed_out; i++)
            send_packet(i);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((chk_pending != 0 || ts_out_valid) && waited < DRAIN_TIMEOUT)
        begin
            @(negedge clk);
            waited++;
        end
        if (chk_pending != 0 || ts_out_valid)
        begin
            $display("Timeout at %0t ns: %0d expected bytes still missing after %0d cycles",
                     $time, chk_pending, waited);
            timed_out = 1'b1;
            tb_errs++;
        end
    endtask

    // reader held off, input side has to back up
    task automatic stall_check();
        int waited;
        waited = 0;
        while (ts_in_ready && waited < READY_TIMEOUT && !timed_out)
        begin
            @(negedge clk);
            waited++;
        end
        if (ts_in_ready)
        begin
            $display("ts_in_ready never went low while the reader was stalled");
            tb_errs++;
        end
        repeat (STALL_HOLD) @(negedge clk);
        req_mode = REQ_HIGH;
    endtask

    task automatic end_test(input int num, input string name, input int errs_before);
        int errs;
        errs = total_errs() - errs_before;
        if (errs == 0)
            $display("test %0d %s: ok", num, name);
        else
        begin
            $display("test %0d %s: %0d errors", num, name, errs);
            failed_tests++;
        end
    endtask

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reader request, driven on the falling edge
    initial
    begin
        logic [31:0] rnd;
        int          low_left;
        rnd        = 32'd45;
        low_left   = 0;
        ts_out_req = 1'b0;
        forever
        begin
            @(negedge clk);
            if (req_mode == REQ_HIGH)
                ts_out_req = 1'b1;
            else if (req_mode == REQ_LOW)
                ts_out_req = 1'b0;
            else
            begin
                rnd = xorshift32(rnd);
                if (low_left > 0)
                begin
                    ts_out_req = 1'b0;
                    low_left--;
                end
                else if (rnd[7:0] < 8'd6)
                begin
                    ts_out_req = 1'b0;
                    low_left   = 24 + int'(rnd[13:8]);    // long gap
                end
                else
                    ts_out_req = rnd[16] | rnd[17];
            end
        end
    end

    initial
    begin
        int errs_before;
        rst          = 1'b1;
        ts_in_data   = '0;
        ts_in_valid  = 1'b0;
        ts_in_sop    = 1'b0;
        ts_in_eop    = 1'b0;
        ts_in_chan   = '0;
        drop_mask    = '0;
        exp_push     = 1'b0;
        exp_chan     = '0;
        exp_start    = '0;
        req_mode     = REQ_HIGH;
        n_vec        = 0;
        kept_total   = 0;
        tb_errs      = 0;
        failed_tests = 0;
        timed_out    = 1'b0;
        read_vectors();
        if (n_vec <= GRP_STALL)
        begin
            $display("The vector file holds only %0d packets", n_vec);
            tb_errs++;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        errs_before = total_errs();
        @(negedge clk);
        if (ts_out_valid !== 1'b0 || ts_in_ready !== 1'b1)
        begin
            $display("Mismatch at %0t ns: after reset ts_out_valid %b ts_in_ready %b",
                     $time, ts_out_valid, ts_in_ready);
            tb_errs++;
        end
        end_test(1, "reset state", errs_before);

        errs_before = total_errs();
        send_range(0, GRP_DROP);
        wait_drain();
        end_test(2, "in order packets", errs_before);

        errs_before = total_errs();
        send_range(GRP_DROP, GRP_RAND);
        wait_drain();
        end_test(3, "dropped channels", errs_before);

        errs_before = total_errs();
        req_mode = REQ_RAND;
        send_range(GRP_RAND, GRP_STALL);
        wait_drain();
        req_mode = REQ_HIGH;
        end_test(4, "random request", errs_before);

        errs_before = total_errs();
        req_mode = REQ_LOW;
        fork
            send_range(GRP_STALL, n_vec);
            stall_check();
        join
        wait_drain();
        end_test(5, "reader stall", errs_before);

        errs_before = total_errs();
        repeat (64) @(negedge clk);    // quiet period for stray bytes
        if (chk_bytes != PKT_BYTES * kept_total || chk_syncs != kept_total)
        begin
            $display("Mismatch at %0t ns: %0d bytes and %0d sync marks, expected %0d and %0d",
                     $time, chk_bytes, chk_syncs, PKT_BYTES * kept_total, kept_total);
            tb_errs++;
        end
        end_test(6, "byte count", errs_before);

        $display("summary: 6 tests, %0d failed, %0d packets, %0d bytes, %0d errors",
                 failed_tests, chk_syncs, chk_bytes, total_errs());
        if (total_errs() == 0 && failed_tests == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== tb/ts_checker.sv ====
// scoreboard for the TS byte stream, the testbench queues expected packets
// every byte taken by the reader is compared in order
`timescale 1ns/1ps

module ts_checker #(
    parameter int CHAN_W = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [7:0]        ts_out_data,
    input  logic              ts_out_valid,
    input  logic              ts_out_sync,
    input  logic [CHAN_W-1:0] ts_out_chan,
    input  logic              ts_out_req,
    input  logic              exp_push,
    input  logic [CHAN_W-1:0] exp_chan,
    input  logic [7:0]        exp_start,
    output int                err_cnt,
    output int                byte_cnt,
    output int                sync_cnt,
    output int                pending
);
    localparam int         PKT_BYTES = 188;
    localparam logic [7:0] SYNC_BYTE = 8'h47;

    logic [7:0]        exp_data [$];
    logic              exp_sync [$];
    logic [CHAN_W-1:0] exp_chan_q [$];

    task automatic queue_packet(input logic [CHAN_W-1:0] chan, input logic [7:0] start);
        for (int k = 0; k < PKT_BYTES; k++)
        begin
            exp_data.push_back(k == 0 ? SYNC_BYTE : 8'(start + k));
            exp_sync.push_back(k == 0);
            exp_chan_q.push_back(chan);
        end
    endtask

    task automatic check_byte();
        logic [7:0]        want_data;
        logic              want_sync;
        logic [CHAN_W-1:0] want_chan;
        int                pkt;
        int                pos;
        pkt = byte_cnt / PKT_BYTES;
        pos = byte_cnt % PKT_BYTES;
        if (exp_data.size() == 0)
        begin
            $display("Unexpected output byte %h at %0t ns, no packet is expected",
                     ts_out_data, $time);
            err_cnt++;
        end
        else
        begin
            want_data = exp_data.pop_front();
            want_sync = exp_sync.pop_front();
            want_chan = exp_chan_q.pop_front();
            if (ts_out_data !== want_data)
            begin
                $display("Mismatch at %0t ns: packet %0d byte %0d is %h, expected %h",
                         $time, pkt, pos, ts_out_data, want_data);
                err_cnt++;
            end
            if (ts_out_sync !== want_sync)
            begin
                $display("Mismatch at %0t ns: packet %0d byte %0d sync %b, expected %b",
                         $time, pkt, pos, ts_out_sync, want_sync);
                err_cnt++;
            end
            if (ts_out_chan !== want_chan)
            begin
                $display("Mismatch at %0t ns: packet %0d channel %0d, expected %0d",
                         $time, pkt, ts_out_chan, want_chan);
                err_cnt++;
            end
        end
        byte_cnt++;
        if (ts_out_sync)
            sync_cnt++;
    endtask

    always @(posedge clk)
    begin
        if (!rst && ts_out_valid && ts_out_req)    // byte moves on this edge
            check_byte();
        if (exp_push)
            queue_packet(exp_chan, exp_start);
        pending = exp_data.size();
    end

endmodule

// ==== rtl/ts_stream_top.sv ====
// single clock TS write path: filter, 32 to 128 packer, beat buffer, byte reader
// drop_mask removes whole packets per channel
`timescale 1ns/1ps

module ts_stream_top #(
    parameter int CHAN_W    = 2,
    parameter int BUF_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [ts_pkg::TS_WORD_W-1:0] ts_in_data,
    input  logic                         ts_in_valid,
    input  logic                         ts_in_sop,
    input  logic                         ts_in_eop,
    input  logic [CHAN_W-1:0]            ts_in_chan,
    input  logic [2**CHAN_W-1:0]         drop_mask,
    output logic                         ts_in_ready,
    output logic [7:0]                   ts_out_data,
    output logic                         ts_out_valid,
    output logic                         ts_out_sync,
    output logic [CHAN_W-1:0]            ts_out_chan,
    input  logic                         ts_out_req
);
    import ts_pkg::*;

    logic [TS_WORD_W-1:0] filt_data;
    logic                 filt_valid;
    logic                 filt_sop;
    logic                 filt_eop;
    logic [CHAN_W-1:0]    filt_chan;
    logic                 pack_ready;

    logic [BEAT_W-1:0]    wr_beat;
    logic [CHAN_W-1:0]    wr_chan;
    logic                 wr_first;
    logic                 wr_valid;
    logic                 wr_credit;

    logic [BEAT_W-1:0]    rd_beat;
    logic [CHAN_W-1:0]    rd_chan;
    logic                 rd_first;
    logic                 rd_valid;
    logic                 rd_credit;

    ts_pkt_filter #(
        .CHAN_W      (CHAN_W)
    ) u_filter (
        .clk         (clk),
        .rst         (rst),
        .ts_in_data  (ts_in_data),
        .ts_in_valid (ts_in_valid),
        .ts_in_sop   (ts_in_sop),
        .ts_in_eop   (ts_in_eop),
        .ts_in_chan  (ts_in_chan),
        .drop_mask   (drop_mask),
        .ts_in_ready (ts_in_ready),
        .filt_data   (filt_data),
        .filt_valid  (filt_valid),
        .filt_sop    (filt_sop),
        .filt_eop    (filt_eop),
        .filt_chan   (filt_chan),
        .pack_ready  (pack_ready)
    );

    ts_beat_packer #(
        .CHAN_W     (CHAN_W),
        .BUF_DEPTH  (BUF_DEPTH)
    ) u_packer (
        .clk        (clk),
        .rst        (rst),
        .filt_data  (filt_data),
        .filt_valid (filt_valid),
        .filt_sop   (filt_sop),
        .filt_eop   (filt_eop),
        .filt_chan  (filt_chan),
        .pack_ready (pack_ready),
        .wr_beat    (wr_beat),
        .wr_chan    (wr_chan),
        .wr_first   (wr_first),
        .wr_valid   (wr_valid),
        .wr_credit  (wr_credit)
    );

    beat_buffer #(
        .CHAN_W    (CHAN_W),
        .BUF_DEPTH (BUF_DEPTH)
    ) u_buffer (
        .clk       (clk),
        .rst       (rst),
        .wr_beat   (wr_beat),
        .wr_chan   (wr_chan),
        .wr_first  (wr_first),
        .wr_valid  (wr_valid),
        .wr_credit (wr_credit),
        .rd_beat   (rd_beat),
        .rd_chan   (rd_chan),
        .rd_first  (rd_first),
        .rd_valid  (rd_valid),
        .rd_credit (rd_credit)
    );

    ts_byte_unpacker #(
        .CHAN_W       (CHAN_W)
    ) u_unpacker (
        .clk          (clk),
        .rst          (rst),
        .rd_beat      (rd_beat),
        .rd_chan      (rd_chan),
        .rd_first     (rd_first),
        .rd_valid     (rd_valid),
        .rd_credit    (rd_credit),
        .ts_out_data  (ts_out_data),
        .ts_out_valid (ts_out_valid),
        .ts_out_sync  (ts_out_sync),
        .ts_out_chan  (ts_out_chan),
        .ts_out_req   (ts_out_req)
    );

endmodule

// ==== rtl/ts_byte_unpacker.sv ====
// two beat slots serialized into a byte stream under the reader's request
// padding after byte 187 is skipped, each freed slot returns a credit
`timescale 1ns/1ps

module ts_byte_unpacker #(
    parameter int CHAN_W = 2
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [ts_pkg::BEAT_W-1:0] rd_beat,
    input  logic [CHAN_W-1:0]         rd_chan,
    input  logic                      rd_first,
    input  logic                      rd_valid,
    output logic                      rd_credit,
    output logic [7:0]                ts_out_data,
    output logic                      ts_out_valid,
    output logic                      ts_out_sync,
    output logic [CHAN_W-1:0]         ts_out_chan,
    input  logic                      ts_out_req
);
    import ts_pkg::*;

    localparam int SEL_W  = (CONS_SLOTS > 1) ? $clog2(CONS_SLOTS) : 1;
    localparam int BYTE_W = $clog2(BEAT_W / 8);
    localparam int PCNT_W = $clog2(TS_PKT_BYTES);

    logic [BEAT_W-1:0]     slot_beat [CONS_SLOTS];
    logic [CHAN_W-1:0]     slot_chan [CONS_SLOTS];
    logic [CONS_SLOTS-1:0] slot_first;
    logic [CONS_SLOTS-1:0] slot_vld;

    logic [SEL_W-1:0]  wr_sel;       // next slot to fill
    logic [SEL_W-1:0]  rd_sel;       // slot being read out
    logic [BYTE_W-1:0] byte_idx;
    logic [PCNT_W-1:0] pkt_cnt;
    logic              take;
    logic              last_byte;
    logic              free_slot;

    assign ts_out_valid = slot_vld[rd_sel];
    assign ts_out_data  = slot_beat[rd_sel][BEAT_W - 1 - 8 * int'(byte_idx) -: 8];
    assign ts_out_sync  = ts_out_valid && slot_first[rd_sel] && byte_idx == '0;
    assign ts_out_chan  = slot_chan[rd_sel];

    assign take      = ts_out_valid && ts_out_req;
    assign last_byte = pkt_cnt == PCNT_W'(TS_PKT_BYTES - 1);
    assign free_slot = take && (last_byte || byte_idx == '1);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            slot_vld  <= '0;
            wr_sel    <= '0;
            rd_sel    <= '0;
            byte_idx  <= '0;
            pkt_cnt   <= '0;
            rd_credit <= 1'b0;
        end
        else
        begin
            if (rd_valid)
            begin
                slot_vld[wr_sel] <= 1'b1;
                wr_sel <= (wr_sel == SEL_W'(CONS_SLOTS - 1)) ? '0 : wr_sel + 1'b1;
            end
            if (free_slot)
            begin
                slot_vld[rd_sel] <= 1'b0;
                rd_sel <= (rd_sel == SEL_W'(CONS_SLOTS - 1)) ? '0 : rd_sel + 1'b1;
            end
            if (take)
            begin
                byte_idx <= free_slot ? '0 : byte_idx + 1'b1;
                if (last_byte)
                    pkt_cnt <= '0;
                else if (ts_out_sync)
                    pkt_cnt <= PCNT_W'(1);    // realign on the first beat
                else
                    pkt_cnt <= pkt_cnt + 1'b1;
            end
            rd_credit <= free_slot;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_valid)
        begin
            slot_beat[wr_sel]  <= rd_beat;
            slot_chan[wr_sel]  <= rd_chan;
            slot_first[wr_sel] <= rd_first;
        end
    end

    // a byte offered without request stays put until taken
    a_hold_byte : assert property (@(posedge clk) disable iff (rst)
        ts_out_valid && !ts_out_req |=> ts_out_valid && $stable(ts_out_data));

endmodule

// ==== rtl/beat_buffer.sv ====
// on-chip beat store between packer and unpacker, credit based on both sides
// producer credits come back on each pop, consumer credits gate the pops
`timescale 1ns/1ps

module beat_buffer #(
    parameter int CHAN_W    = 2,
    parameter int BUF_DEPTH = 8
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [ts_pkg::BEAT_W-1:0] wr_beat,
    input  logic [CHAN_W-1:0]         wr_chan,
    input  logic                      wr_first,
    input  logic                      wr_valid,
    output logic                      wr_credit,
    output logic [ts_pkg::BEAT_W-1:0] rd_beat,
    output logic [CHAN_W-1:0]         rd_chan,
    output logic                      rd_first,
    output logic                      rd_valid,
    input  logic                      rd_credit
);
    import ts_pkg::*;

    localparam int PTR_W  = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
    localparam int CNT_W  = $clog2(BUF_DEPTH + 1);
    localparam int CCNT_W = $clog2(CONS_SLOTS + 1);

    logic [BEAT_W-1:0] beat_mem  [BUF_DEPTH];
    logic [CHAN_W-1:0] chan_mem  [BUF_DEPTH];
    logic              first_mem [BUF_DEPTH];

    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic [CCNT_W-1:0] cons_cnt;     // free unpacker slots
    logic              pop;

    assign pop = count != '0 && cons_cnt != '0;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            cons_cnt  <= CCNT_W'(CONS_SLOTS);
            rd_valid  <= 1'b0;
            wr_credit <= 1'b0;
        end
        else
        begin
            if (wr_valid)
                wr_ptr <= (wr_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count     <= count + CNT_W'(wr_valid) - CNT_W'(pop);
            cons_cnt  <= cons_cnt + CCNT_W'(rd_credit) - CCNT_W'(pop);
            rd_valid  <= pop;
            wr_credit <= pop;    // entry freed
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_valid)
        begin
            beat_mem[wr_ptr]  <= wr_beat;
            chan_mem[wr_ptr]  <= wr_chan;
            first_mem[wr_ptr] <= wr_first;
        end
        if (pop)
        begin
            rd_beat  <= beat_mem[rd_ptr];
            rd_chan  <= chan_mem[rd_ptr];
            rd_first <= first_mem[rd_ptr];
        end
    end

    // packer credit accounting keeps writes off a full FIFO
    a_no_overflow : assert property (@(posedge clk) disable iff (rst)
        wr_valid |-> count < CNT_W'(BUF_DEPTH));

endmodule

// ==== rtl/ts_beat_packer.sv ====
// packs 32-bit TS words into 128-bit beats, zero pads the last beat of a packet
// writes toward the beat buffer only while holding a credit
`timescale 1ns/1ps

module ts_beat_packer #(
    parameter int CHAN_W    = 2,
    parameter int BUF_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [ts_pkg::TS_WORD_W-1:0] filt_data,
    input  logic                         filt_valid,
    input  logic                         filt_sop,
    input  logic                         filt_eop,
    input  logic [CHAN_W-1:0]            filt_chan,
    output logic                         pack_ready,
    output logic [ts_pkg::BEAT_W-1:0]    wr_beat,
    output logic [CHAN_W-1:0]            wr_chan,
    output logic                         wr_first,
    output logic                         wr_valid,
    input  logic                         wr_credit
);
    import ts_pkg::*;

    localparam int CRED_W = $clog2(BUF_DEPTH + 1);
    localparam int WCNT_W = $clog2(BEAT_WORDS);
    localparam int BIDX_W = $clog2(PKT_BEATS);
    localparam int ACC_W  = TS_WORD_W * (BEAT_WORDS - 1);

    logic [ACC_W-1:0]  acc;          // words already taken for this beat
    logic [WCNT_W-1:0] word_cnt;
    logic [BIDX_W-1:0] beat_idx;
    logic [BIDX_W-1:0] cur_idx;
    logic [CRED_W-1:0] credit_cnt;
    logic              beat_full;
    logic              close_beat;
    logic [BEAT_W-1:0] closed;

    assign close_beat = filt_valid && (filt_eop || word_cnt == WCNT_W'(BEAT_WORDS - 1));
    assign cur_idx    = filt_sop ? '0 : beat_idx;

    // word 0 ends up in the top bits, missing words become zero padding
    assign closed = {acc, filt_data} << (TS_WORD_W * (BEAT_WORDS - 1 - int'(word_cnt)));

    assign wr_valid   = beat_full && credit_cnt != '0;
    assign pack_ready = !(beat_full && credit_cnt == '0);   // finished beat stuck

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            word_cnt   <= '0;
            beat_idx   <= '0;
            beat_full  <= 1'b0;
            credit_cnt <= CRED_W'(BUF_DEPTH);
        end
        else
        begin
            if (filt_valid)
                word_cnt <= close_beat ? '0 : word_cnt + 1'b1;

            if (close_beat)
                beat_idx <= filt_eop ? '0 : cur_idx + 1'b1;
            else if (filt_valid && filt_sop)
                beat_idx <= '0;

            if (close_beat)
                beat_full <= 1'b1;
            else if (wr_valid)
                beat_full <= 1'b0;

            credit_cnt <= credit_cnt + CRED_W'(wr_credit) - CRED_W'(wr_valid);
        end
    end

    always_ff @(posedge clk)
    begin
        if (filt_valid)
            acc <= {acc[ACC_W-TS_WORD_W-1:0], filt_data};
        if (close_beat)
        begin
            wr_beat  <= closed;
            wr_chan  <= filt_chan;
            wr_first <= cur_idx == '0;
        end
    end

    // buffer never returns more entries than it has
    a_credit_max : assert property (@(posedge clk) disable iff (rst)
        credit_cnt <= CRED_W'(BUF_DEPTH));

    // every packet closes on its twelfth beat
    a_pkt_beats : assert property (@(posedge clk) disable iff (rst)
        close_beat && filt_eop |-> cur_idx == BIDX_W'(PKT_BEATS - 1));

endmodule

// ==== rtl/ts_pkt_filter.sv ====
// input stage: drops whole packets of masked channels, registers the rest
// ready is passed straight through from the packer
`timescale 1ns/1ps

module ts_pkt_filter #(
    parameter int CHAN_W = 2
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [ts_pkg::TS_WORD_W-1:0] ts_in_data,
    input  logic                         ts_in_valid,
    input  logic                         ts_in_sop,
    input  logic                         ts_in_eop,
    input  logic [CHAN_W-1:0]            ts_in_chan,
    input  logic [2**CHAN_W-1:0]         drop_mask,
    output logic                         ts_in_ready,
    output logic [ts_pkg::TS_WORD_W-1:0] filt_data,
    output logic                         filt_valid,
    output logic                         filt_sop,
    output logic                         filt_eop,
    output logic [CHAN_W-1:0]            filt_chan,
    input  logic                         pack_ready
);
    import ts_pkg::*;

    localparam int WCNT_W = $clog2(TS_PKT_WORDS);

    logic              accept;
    logic              drop_now;
    logic              drop_q;
    logic [CHAN_W-1:0] chan_now;
    logic [CHAN_W-1:0] chan_q;
    logic [WCNT_W-1:0] wcnt;       // word index inside the packet

    assign ts_in_ready = pack_ready;
    assign accept      = ts_in_valid && ts_in_ready;

    // sop word uses the live mask and channel, later words the latched ones
    assign drop_now = ts_in_sop ? drop_mask[ts_in_chan] : drop_q;
    assign chan_now = ts_in_sop ? ts_in_chan : chan_q;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            filt_valid <= 1'b0;
            drop_q     <= 1'b0;
            wcnt       <= '0;
        end
        else
        begin
            filt_valid <= accept && !drop_now;
            if (accept && ts_in_sop)
                drop_q <= drop_mask[ts_in_chan];
            if (accept)
            begin
                if (ts_in_eop)
                    wcnt <= '0;
                else if (ts_in_sop)
                    wcnt <= WCNT_W'(1);
                else
                    wcnt <= wcnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            filt_data <= ts_in_data;
            filt_sop  <= ts_in_sop;
            filt_eop  <= ts_in_eop;
            filt_chan <= chan_now;
            chan_q    <= chan_now;
        end
    end

    // a packet opens on a sync byte and eop lands on its 47th word
    a_sop_frame : assert property (@(posedge clk) disable iff (rst)
        accept && ts_in_sop |-> wcnt == '0 && ts_in_data[TS_WORD_W-1 -: 8] == TS_SYNC_BYTE);
    a_eop_frame : assert property (@(posedge clk) disable iff (rst)
        accept |-> ts_in_eop == (wcnt == WCNT_W'(TS_PKT_WORDS - 1)));

endmodule

// ==== rtl/ts_pkg.sv ====
// constants for the TS write path: packet framing, word and beat geometry
// imported by every RTL module of the stream
package ts_pkg;

    // transport stream packet
    localparam int TS_PKT_BYTES = 188;
    localparam int TS_WORD_W    = 32;
    localparam int TS_PKT_WORDS = TS_PKT_BYTES / (TS_WORD_W / 8);   // 47

    localparam logic [7:0] TS_SYNC_BYTE = 8'h47;

    // 128-bit beats toward the buffer
    localparam int BEAT_W     = 128;
    localparam int BEAT_WORDS = BEAT_W / TS_WORD_W;                  // 4

    // last beat of a packet is closed early and zero padded
    localparam int PKT_BEATS = (TS_PKT_WORDS + BEAT_WORDS - 1) / BEAT_WORDS;

    // unpacker beat slots, also its starting credit count
    localparam int CONS_SLOTS = 2;

endpackage
